//--- delayed_pulser.sv
`timescale 1ns/1ps
`include "us_settings.svh"

module delayed_pulser #(
	parameter int DELAY = `US_START_DELAY // cycles from edge to pulse
) (
	input logic clock_50,
	input logic rst_n,
	input logic level,
	output logic pulse
);

	localparam int CW = $clog2(DELAY + 1);

	logic level_q; // previous level for edge detect
	logic busy; // counting down
	logic [CW-1:0] cnt;
	logic rise;

	assign rise = level && !level_q;

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			level_q <= 1'b0;
			busy <= 1'b0;
			cnt <= '0;
			pulse <= 1'b0;
		end else begin
			level_q <= level;
			pulse <= 1'b0; // single cycle only
			if (busy) begin
				if (cnt == '0) begin
					busy <= 1'b0;
					pulse <= 1'b1;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end else if (rise) begin // edges while busy dropped
				busy <= 1'b1;
				cnt <= CW'(DELAY - 1);
			end
		end
	end

endmodule

//--- lm96570_spi.sv
`timescale 1ns/1ps
`include "us_settings.svh"

module lm96570_spi (
	input logic clock_50,
	input logic rst_n,
	spi_cmd_if.slave cmd,
	output logic cs_n,
	output logic sck,
	output logic sdo,
	input logic sdi
);

	localparam int DW = `US_SPI_DATA_WIDTH;
	localparam int HALF = `US_SCK_HALF_DIV;
	localparam int DIV_W = $clog2(HALF + 1);

	us_seq_pkg::spi_state_e state;
	logic [DIV_W-1:0] div_cnt; // half period timer
	logic div_tick;
	logic phase; // 0 sck low half, 1 high half
	logic [`US_BIT_COUNT_WIDTH-1:0] bits_left;
	logic [DW-1:0] tx_sh; // msb goes out first
	logic [DW-1:0] rx_sh; // fills from bit 0
	logic [DW-1:0] tx_aligned;
	logic start_ok;

	assign tx_aligned = cmd.tx_data << (DW - cmd.num_bits); // bit num_bits-1 to top
	assign div_tick = (div_cnt == DIV_W'(HALF - 1));
	assign start_ok = cmd.start && (state != us_seq_pkg::SPI_SHIFT); // busy ignores start
	assign cmd.done = (state == us_seq_pkg::SPI_DONE);

	// ==============================
	// control and pins
	// ==============================
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state <= us_seq_pkg::SPI_IDLE;
			cs_n <= 1'b1;
			sck <= 1'b0;
			sdo <= 1'b0;
			div_cnt <= '0;
			phase <= 1'b0;
			bits_left <= '0;
			cmd.rx_data <= '0;
		end else if (start_ok) begin
			state <= us_seq_pkg::SPI_SHIFT;
			cs_n <= 1'b0;
			sck <= 1'b0;
			sdo <= tx_aligned[DW-1]; // first bit before first rise
			div_cnt <= '0;
			phase <= 1'b0;
			bits_left <= cmd.num_bits;
		end else if (state == us_seq_pkg::SPI_SHIFT) begin
			div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
			if (div_tick && !phase) begin
				if (bits_left == '0) begin // trailing half period over
					state <= us_seq_pkg::SPI_DONE;
					cs_n <= 1'b1;
					sdo <= 1'b0;
					cmd.rx_data <= rx_sh;
				end else begin
					sck <= 1'b1; // rising edge, sdi sampled
					phase <= 1'b1;
				end
			end else if (div_tick) begin
				sck <= 1'b0; // falling edge, next bit out
				phase <= 1'b0;
				bits_left <= bits_left - 1'b1;
				sdo <= tx_sh[DW-2];
			end
		end
	end

	// shift registers
	always_ff @(posedge clock_50) begin
		if (start_ok) begin
			tx_sh <= tx_aligned;
			rx_sh <= '0; // upper bits read back as zero
		end else if (state == us_seq_pkg::SPI_SHIFT && div_tick) begin
			if (!phase && bits_left != '0) begin
				rx_sh <= {rx_sh[DW-2:0], sdi};
			end
			if (phase) begin
				tx_sh <= {tx_sh[DW-2:0], 1'b0};
			end
		end
	end

endmodule

//--- pulse_echo_fsm.sv
`timescale 1ns/1ps
`include "us_settings.svh"

module pulse_echo_fsm (
	input logic clock_50,
	input logic rst_n,
	acq_cfg_if.slave cfg,
	output logic tx_en,
	output logic fifo_en
);

	localparam int TW = `US_TIMER_WIDTH;

	us_seq_pkg::acq_state_e state;
	logic [TW-1:0] cnt; // shared phase timer
	logic [TW-1:0] dly_q; // latched at start
	logic [TW-1:0] smp_q;
	logic last; // final cycle of a phase
	logic start_ok;

	assign last = (cnt == TW'(1));
	assign start_ok = cfg.start &&
		(state == us_seq_pkg::ACQ_IDLE || state == us_seq_pkg::ACQ_DONE);
	assign tx_en = (state == us_seq_pkg::ACQ_TX);
	assign fifo_en = (state == us_seq_pkg::ACQ_WINDOW);
	assign cfg.done = (state == us_seq_pkg::ACQ_DONE); // follows last window cycle

	// running sequence keeps its own copy
	always_ff @(posedge clock_50) begin
		if (start_ok) begin
			dly_q <= cfg.init_delay;
			smp_q <= cfg.samples;
		end
	end

	// ==============================
	// sequence, zero lengths skipped
	// ==============================
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state <= us_seq_pkg::ACQ_IDLE;
			cnt <= '0;
		end else if (start_ok) begin
			if (cfg.tx_len != '0) begin
				state <= us_seq_pkg::ACQ_TX;
				cnt <= cfg.tx_len;
			end else if (cfg.init_delay != '0) begin
				state <= us_seq_pkg::ACQ_DELAY;
				cnt <= cfg.init_delay;
			end else if (cfg.samples != '0) begin
				state <= us_seq_pkg::ACQ_WINDOW;
				cnt <= cfg.samples;
			end else begin
				state <= us_seq_pkg::ACQ_DONE;
			end
		end else begin
			case (state)
				us_seq_pkg::ACQ_TX: begin
					if (!last) begin
						cnt <= cnt - 1'b1;
					end else if (dly_q != '0) begin
						state <= us_seq_pkg::ACQ_DELAY;
						cnt <= dly_q;
					end else if (smp_q != '0) begin
						state <= us_seq_pkg::ACQ_WINDOW;
						cnt <= smp_q;
					end else begin
						state <= us_seq_pkg::ACQ_DONE;
					end
				end
				us_seq_pkg::ACQ_DELAY: begin
					if (!last) begin
						cnt <= cnt - 1'b1;
					end else if (smp_q != '0) begin
						state <= us_seq_pkg::ACQ_WINDOW;
						cnt <= smp_q;
					end else begin
						state <= us_seq_pkg::ACQ_DONE;
					end
				end
				us_seq_pkg::ACQ_WINDOW: begin
					if (!last) begin
						cnt <= cnt - 1'b1;
					end else begin
						state <= us_seq_pkg::ACQ_DONE;
					end
				end
				default: ; // idle or done waits for start
			endcase
		end
	end

endmodule

//--- sim.f
+incdir+.
us_regs_pkg.sv
us_seq_pkg.sv
us_ifs.sv
delayed_pulser.sv
lm96570_spi.sv
pulse_echo_fsm.sv
us_axil_regs.sv
us_frontend_top.sv
tb_clock_gen.sv
tb_us_frontend.sv

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock_50,
	output logic rst_n
);

	initial begin
		clock_50 = 1'b0;
		forever #5 clock_50 = ~clock_50; // 10 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clock_50); // 8 cycles in reset
		@(negedge clock_50);
		rst_n = 1'b1; // released away from the active edge
	end

endmodule

//--- tb_us_frontend.sv
`timescale 1ns/1ps
`include "us_settings.svh"

module tb_us_frontend;

	localparam int SW = `US_SPI_DATA_WIDTH;
	localparam int PIPE = `US_START_DELAY + 3; // write to first sequencer cycle

	logic clock_50;
	logic rst_n;
	logic [`US_AXI_ADDR_WIDTH-1:0] s_awaddr;
	logic s_awvalid;
	logic s_awready;
	logic [`US_AXI_DATA_WIDTH-1:0] s_wdata;
	logic [`US_AXI_DATA_WIDTH/8-1:0] s_wstrb;
	logic s_wvalid;
	logic s_wready;
	logic [1:0] s_bresp;
	logic s_bvalid;
	logic s_bready;
	logic [`US_AXI_ADDR_WIDTH-1:0] s_araddr;
	logic s_arvalid;
	logic s_arready;
	logic [`US_AXI_DATA_WIDTH-1:0] s_rdata;
	logic [1:0] s_rresp;
	logic s_rvalid;
	logic s_rready;
	logic bf_spi_cs_n;
	logic bf_spi_sck;
	logic bf_spi_sdo;
	logic bf_spi_sdi;
	logic bf_tx_en;
	logic bf_reset;
	logic pulser_en;
	logic txrx_spi_en;
	logic txrx_sw_off;
	logic [`US_MUX_WIDTH-1:0] mux_cnt;
	logic fifo_en;

	// monitor counters, updated on the rising edge only
	int cyc = 0;
	int sck_rises = 0;
	int tx_high = 0;
	int fifo_high = 0;
	int fifo_rise_cyc = 0;
	int go_cyc = 0;
	int aw_hs = 0; // address write handshakes
	int w_hs = 0;
	int ar_hs = 0;
	logic sck_q = 1'b0;
	logic fifo_q = 1'b0;

	assign bf_spi_sdi = bf_spi_sdo; // serial loopback

	tb_clock_gen u_clk (
		.clock_50 (clock_50),
		.rst_n (rst_n)
	);

	us_frontend_top dut0 (
		.clock_50 (clock_50),
		.rst_n (rst_n),
		.s_awaddr (s_awaddr),
		.s_awvalid (s_awvalid),
		.s_awready (s_awready),
		.s_wdata (s_wdata),
		.s_wstrb (s_wstrb),
		.s_wvalid (s_wvalid),
		.s_wready (s_wready),
		.s_bresp (s_bresp),
		.s_bvalid (s_bvalid),
		.s_bready (s_bready),
		.s_araddr (s_araddr),
		.s_arvalid (s_arvalid),
		.s_arready (s_arready),
		.s_rdata (s_rdata),
		.s_rresp (s_rresp),
		.s_rvalid (s_rvalid),
		.s_rready (s_rready),
		.bf_spi_cs_n (bf_spi_cs_n),
		.bf_spi_sck (bf_spi_sck),
		.bf_spi_sdo (bf_spi_sdo),
		.bf_spi_sdi (bf_spi_sdi),
		.bf_tx_en (bf_tx_en),
		.bf_reset (bf_reset),
		.pulser_en (pulser_en),
		.txrx_spi_en (txrx_spi_en),
		.txrx_sw_off (txrx_sw_off),
		.mux_cnt (mux_cnt),
		.fifo_en (fifo_en)
	);

	// ==============================
	// pin monitor
	// ==============================
	always @(posedge clock_50) begin
		cyc <= cyc + 1;
		sck_q <= bf_spi_sck;
		fifo_q <= fifo_en;
		if (bf_spi_sck && !sck_q && !bf_spi_cs_n) begin
			sck_rises <= sck_rises + 1; // rises inside the frame
		end
		if (bf_tx_en) begin
			tx_high <= tx_high + 1;
		end
		if (fifo_en) begin
			fifo_high <= fifo_high + 1;
		end
		if (fifo_en && !fifo_q) begin
			fifo_rise_cyc <= cyc;
		end
		if (s_awvalid && s_awready && s_awaddr == us_regs_pkg::REG_CTRL && s_wdata[1]) begin
			go_cyc <= cyc; // acq_go write accepted
		end
		if (s_awvalid && s_awready) begin
			aw_hs <= aw_hs + 1;
		end
		if (s_wvalid && s_wready) begin
			w_hs <= w_hs + 1;
		end
		if (s_arvalid && s_arready) begin
			ar_hs <= ar_hs + 1;
		end
	end

	// expected rx word, only the shifted bits come back
	function automatic logic [SW-1:0] ref_spi_rx(input logic [SW-1:0] tx, input int nbits);
		logic [SW-1:0] mask;
		mask = '0;
		for (int i = 0; i < nbits; i++) begin
			mask[i] = 1'b1;
		end
		return tx & mask;
	endfunction

	// cycles from the acq_go handshake to the first window cycle
	function automatic int ref_fifo_offset(input int tx_len, input int init_delay);
		return PIPE + tx_len + init_delay; // tx phase then gap
	endfunction

	task automatic check_value(input string name, input logic [SW-1:0] exp,
			input logic [SW-1:0] act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clock_50);
	endtask

	// ==============================
	// axi4-lite master tasks
	// ==============================
	task automatic write_reg(input logic [5:0] addr, input logic [31:0] data,
			input logic [1:0] exp_resp, input string name);
		int n;
		int aw0;
		int w0;
		n = 0;
		aw0 = aw_hs;
		w0 = w_hs;
		s_awaddr = addr;
		s_wdata = data;
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
		s_bready = 1'b1;
		do begin
			@(negedge clock_50);
			n++;
			if (n > 50) begin
				timeout_fail("write response");
			end
		end while (!s_bvalid);
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		check_value({name, " bresp"}, exp_resp, s_bresp);
		check_value({name, " awready handshakes"}, 1, aw_hs - aw0);
		check_value({name, " wready handshakes"}, 1, w_hs - w0);
	endtask

	task automatic read_reg(input logic [5:0] addr, input int stall,
			input logic [1:0] exp_resp, output logic [31:0] data);
		int n;
		int ar0;
		logic [31:0] held;
		n = 0;
		ar0 = ar_hs;
		s_araddr = addr;
		s_arvalid = 1'b1;
		s_rready = (stall == 0); // low means back-pressure
		do begin
			@(negedge clock_50);
			n++;
			if (n > 50) begin
				timeout_fail("read data");
			end
		end while (!s_rvalid);
		s_arvalid = 1'b0;
		held = s_rdata;
		check_value("rresp", exp_resp, s_rresp);
		check_value("arready handshakes", 1, ar_hs - ar0);
		for (int i = 0; i < stall; i++) begin
			@(negedge clock_50);
			check_value("stall rvalid", 1, s_rvalid);
			check_value("stall rdata", held, s_rdata);
		end
		if (stall != 0) begin
			s_rready = 1'b1;
			@(negedge clock_50);
			check_value("rvalid after handshake", 0, s_rvalid);
		end
		data = held;
	endtask

	task automatic poll_status(input int bit_idx, input string what, input int limit);
		logic [31:0] st;
		int n;
		n = 0;
		do begin
			read_reg(us_regs_pkg::REG_STATUS, 0, us_regs_pkg::RESP_OKAY, st);
			n++;
			if (n > limit) begin
				timeout_fail(what);
			end
		end while (!st[bit_idx]);
	endtask

	task automatic write_read_back(input logic [5:0] addr, input logic [31:0] mask,
			input string name);
		logic [31:0] val;
		logic [31:0] rd;
		val = $urandom;
		write_reg(addr, val, us_regs_pkg::RESP_OKAY, name);
		read_reg(addr, 0, us_regs_pkg::RESP_OKAY, rd);
		check_value(name, val & mask, rd); // only implemented bits stick
	endtask

	task automatic run_echo(input string name);
		int tx_len;
		int dly;
		int smp;
		int tx0;
		int fifo0;
		tx_len = $urandom % 41;
		dly = $urandom % 41;
		smp = $urandom % 41;
		write_reg(us_regs_pkg::REG_TX_LEN, tx_len, us_regs_pkg::RESP_OKAY, name);
		write_reg(us_regs_pkg::REG_INIT_DELAY, dly, us_regs_pkg::RESP_OKAY, name);
		write_reg(us_regs_pkg::REG_SAMPLES, smp, us_regs_pkg::RESP_OKAY, name);
		tx0 = tx_high;
		fifo0 = fifo_high;
		write_reg(us_regs_pkg::REG_CTRL, 32'h2, us_regs_pkg::RESP_OKAY, name); // acq_go
		idle_cycles(PIPE); // old done clears on start
		poll_status(us_regs_pkg::STAT_ACQ_DONE, "acquisition done", 200);
		check_value({name, " tx_en cycles"}, tx_len, tx_high - tx0);
		check_value({name, " fifo_en cycles"}, smp, fifo_high - fifo0);
		if (smp != 0) begin
			check_value({name, " window start"}, ref_fifo_offset(tx_len, dly),
				fifo_rise_cyc - go_cyc);
		end
		write_reg(us_regs_pkg::REG_CTRL, 32'h0, us_regs_pkg::RESP_OKAY, name); // drop go
	endtask

	// ==============================
	// test sequence
	// ==============================
	initial begin
		int unsigned seed;
		logic [31:0] rd;
		logic [31:0] ctrl;
		logic [31:0] mux_val;
		logic [SW-1:0] tx;
		logic [SW-1:0] exp_rx;
		int nbits;
		int rises0;
		int n;
		seed = $urandom(12);
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wstrb = '1;
		s_wvalid = 1'b0;
		s_bready = 1'b1;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b1;
		n = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clock_50);
			n++;
			if (n > 20) begin
				timeout_fail("reset release");
			end
		end
		@(negedge clock_50);

		// idle levels after reset
		check_value("reset cs_n", 1, bf_spi_cs_n);
		check_value("reset sck", 0, bf_spi_sck);
		check_value("reset tx_en", 0, bf_tx_en);
		check_value("reset fifo_en", 0, fifo_en);
		check_value("reset statics", 0, {pulser_en, txrx_spi_en, txrx_sw_off, bf_reset});
		check_value("reset mux", 0, mux_cnt);
		read_reg(us_regs_pkg::REG_STATUS, 0, us_regs_pkg::RESP_OKAY, rd);
		check_value("reset status", 0, rd);

		// register read-back
		write_read_back(us_regs_pkg::REG_SPI_NBITS, (1 << `US_BIT_COUNT_WIDTH) - 1, "nbits");
		write_read_back(us_regs_pkg::REG_SPI_TX0, 32'hFFFF_FFFF, "tx0");
		write_read_back(us_regs_pkg::REG_SPI_TX1, 32'hFFFF_FFFF, "tx1");
		write_read_back(us_regs_pkg::REG_SPI_TX2, (1 << (SW - 64)) - 1, "tx2");
		write_read_back(us_regs_pkg::REG_INIT_DELAY, 32'hFFFF_FFFF, "init delay");
		write_read_back(us_regs_pkg::REG_SAMPLES, 32'hFFFF_FFFF, "samples");
		write_read_back(us_regs_pkg::REG_TX_LEN, 32'hFFFF_FFFF, "tx len");
		write_read_back(us_regs_pkg::REG_MUX, (1 << `US_MUX_WIDTH) - 1, "mux");
		mux_val = $urandom & ((1 << `US_MUX_WIDTH) - 1); // lines on the mux board
		write_reg(us_regs_pkg::REG_MUX, mux_val, us_regs_pkg::RESP_OKAY, "mux");
		check_value("mux pins", mux_val, mux_cnt);
		ctrl = $urandom & 32'h3C; // static bits only, go bits low
		write_reg(us_regs_pkg::REG_CTRL, ctrl, us_regs_pkg::RESP_OKAY, "ctrl");
		check_value("pulser_en", ctrl[2], pulser_en);
		check_value("txrx_spi_en", ctrl[3], txrx_spi_en);
		check_value("txrx_sw_off", ctrl[4], txrx_sw_off);
		check_value("bf_reset", ctrl[5], bf_reset);
		read_reg(us_regs_pkg::REG_CTRL, 0, us_regs_pkg::RESP_OKAY, rd);
		check_value("ctrl read", ctrl, rd);

		// bus errors
		write_reg(6'h34, $urandom, us_regs_pkg::RESP_SLVERR, "unmapped write");
		write_reg(us_regs_pkg::REG_STATUS, $urandom, us_regs_pkg::RESP_SLVERR, "status write");
		read_reg(6'h3C, 0, us_regs_pkg::RESP_SLVERR, rd);
		check_value("unmapped read data", 0, rd);

		// ==============================
		// spi loopback
		// ==============================
		tx = {$urandom, $urandom, $urandom};
		nbits = 1 + $urandom % SW;
		write_reg(us_regs_pkg::REG_SPI_TX0, tx[31:0], us_regs_pkg::RESP_OKAY, "spi tx0");
		write_reg(us_regs_pkg::REG_SPI_TX1, tx[63:32], us_regs_pkg::RESP_OKAY, "spi tx1");
		write_reg(us_regs_pkg::REG_SPI_TX2, tx[SW-1:64], us_regs_pkg::RESP_OKAY, "spi tx2");
		write_reg(us_regs_pkg::REG_SPI_NBITS, nbits, us_regs_pkg::RESP_OKAY, "spi nbits");
		rises0 = sck_rises;
		write_reg(us_regs_pkg::REG_CTRL, 32'h1, us_regs_pkg::RESP_OKAY, "spi go");
		idle_cycles(PIPE);
		poll_status(us_regs_pkg::STAT_SPI_DONE, "spi done", 1000);
		check_value("spi cs_n after done", 1, bf_spi_cs_n);
		check_value("spi sck rises", nbits, sck_rises - rises0);
		exp_rx = ref_spi_rx(tx, nbits);
		read_reg(us_regs_pkg::REG_SPI_RX0, 0, us_regs_pkg::RESP_OKAY, rd);
		check_value("spi rx0", exp_rx[31:0], rd);
		read_reg(us_regs_pkg::REG_SPI_RX1, 0, us_regs_pkg::RESP_OKAY, rd);
		check_value("spi rx1", exp_rx[63:32], rd);
		read_reg(us_regs_pkg::REG_SPI_RX2, 0, us_regs_pkg::RESP_OKAY, rd);
		check_value("spi rx2", exp_rx[SW-1:64], rd); // upper bits zero
		write_reg(us_regs_pkg::REG_CTRL, 32'h0, us_regs_pkg::RESP_OKAY, "spi go clear");

		// pulse-echo, twice with fresh timings
		run_echo("echo run 1");
		run_echo("echo run 2");

		// read channel back-pressure
		read_reg(us_regs_pkg::REG_MUX, 1 + $urandom % 8, us_regs_pkg::RESP_OKAY, rd);
		check_value("stalled mux read", mux_val, rd);

		$display("TEST OK");
		$finish;
	end

endmodule

//--- us_axil_regs.sv
`timescale 1ns/1ps
`include "us_settings.svh"

module us_axil_regs (
	input logic clock_50,
	input logic rst_n,
	// ==============================
	// axi4-lite slave
	// ==============================
	input logic [`US_AXI_ADDR_WIDTH-1:0] s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input logic [`US_AXI_DATA_WIDTH-1:0] s_wdata,
	input logic [`US_AXI_DATA_WIDTH/8-1:0] s_wstrb, // whole words only
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input logic [`US_AXI_ADDR_WIDTH-1:0] s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output logic [`US_AXI_DATA_WIDTH-1:0] s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,
	// ==============================
	// engines and static controls
	// ==============================
	spi_cmd_if.master spi,
	acq_cfg_if.master acq,
	output logic pulser_en,
	output logic txrx_spi_en,
	output logic txrx_sw_off,
	output logic bf_reset,
	output logic [`US_MUX_WIDTH-1:0] mux_cnt
);

	localparam int DW = `US_AXI_DATA_WIDTH;
	localparam int SW = `US_SPI_DATA_WIDTH;
	localparam int TW = `US_TIMER_WIDTH;
	localparam int BW = `US_BIT_COUNT_WIDTH;
	localparam int MW = `US_MUX_WIDTH;

	us_regs_pkg::ctrl_reg_u ctrl_q; // raw on the bus, fields to logic
	logic [BW-1:0] nbits_q;
	logic [SW-1:0] tx_q; // spread over three words
	logic [TW-1:0] init_delay_q;
	logic [TW-1:0] samples_q;
	logic [TW-1:0] tx_len_q;
	logic [MW-1:0] mux_q;
	logic wr_fire; // aw and w taken together
	logic rd_fire;
	logic wr_err;
	logic rd_err;
	logic [DW-1:0] rd_word;
	logic [DW-1:0] status;

	assign wr_fire = s_awvalid && s_wvalid && !s_bvalid; // one write in flight
	assign rd_fire = s_arvalid && !s_rvalid && !wr_fire; // write wins a tie
	assign s_awready = wr_fire;
	assign s_wready = wr_fire;
	assign s_arready = rd_fire;

	always_comb begin
		status = '0;
		status[us_regs_pkg::STAT_SPI_DONE] = spi.done;
		status[us_regs_pkg::STAT_ACQ_DONE] = acq.done;
	end

	// writable offsets, everything else errors
	always_comb begin
		case (s_awaddr)
			us_regs_pkg::REG_CTRL, us_regs_pkg::REG_SPI_NBITS,
			us_regs_pkg::REG_SPI_TX0, us_regs_pkg::REG_SPI_TX1,
			us_regs_pkg::REG_SPI_TX2, us_regs_pkg::REG_INIT_DELAY,
			us_regs_pkg::REG_SAMPLES, us_regs_pkg::REG_TX_LEN,
			us_regs_pkg::REG_MUX: wr_err = 1'b0;
			default: wr_err = 1'b1;
		endcase
	end

	// read mux
	always_comb begin
		rd_word = '0;
		rd_err = 1'b0;
		case (s_araddr)
			us_regs_pkg::REG_CTRL: rd_word = ctrl_q.raw;
			us_regs_pkg::REG_STATUS: rd_word = status;
			us_regs_pkg::REG_SPI_NBITS: rd_word = DW'(nbits_q);
			us_regs_pkg::REG_SPI_TX0: rd_word = tx_q[DW-1:0];
			us_regs_pkg::REG_SPI_TX1: rd_word = tx_q[2*DW-1:DW];
			us_regs_pkg::REG_SPI_TX2: rd_word = DW'(tx_q[SW-1:2*DW]);
			us_regs_pkg::REG_SPI_RX0: rd_word = spi.rx_data[DW-1:0];
			us_regs_pkg::REG_SPI_RX1: rd_word = spi.rx_data[2*DW-1:DW];
			us_regs_pkg::REG_SPI_RX2: rd_word = DW'(spi.rx_data[SW-1:2*DW]);
			us_regs_pkg::REG_INIT_DELAY: rd_word = DW'(init_delay_q);
			us_regs_pkg::REG_SAMPLES: rd_word = DW'(samples_q);
			us_regs_pkg::REG_TX_LEN: rd_word = DW'(tx_len_q);
			us_regs_pkg::REG_MUX: rd_word = DW'(mux_q);
			default: rd_err = 1'b1; // unmapped reads give zero
		endcase
	end

	// ==============================
	// register file and handshakes
	// ==============================
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			ctrl_q.raw <= '0;
			nbits_q <= '0;
			tx_q <= '0;
			init_delay_q <= '0;
			samples_q <= '0;
			tx_len_q <= '0;
			mux_q <= '0;
			s_bvalid <= 1'b0;
			s_rvalid <= 1'b0;
		end else begin
			if (wr_fire) begin
				s_bvalid <= 1'b1;
				case (s_awaddr)
					us_regs_pkg::REG_CTRL: ctrl_q.raw <= s_wdata;
					us_regs_pkg::REG_SPI_NBITS: nbits_q <= s_wdata[BW-1:0];
					us_regs_pkg::REG_SPI_TX0: tx_q[DW-1:0] <= s_wdata;
					us_regs_pkg::REG_SPI_TX1: tx_q[2*DW-1:DW] <= s_wdata;
					us_regs_pkg::REG_SPI_TX2: tx_q[SW-1:2*DW] <= s_wdata[SW-2*DW-1:0];
					us_regs_pkg::REG_INIT_DELAY: init_delay_q <= TW'(s_wdata);
					us_regs_pkg::REG_SAMPLES: samples_q <= TW'(s_wdata);
					us_regs_pkg::REG_TX_LEN: tx_len_q <= TW'(s_wdata);
					us_regs_pkg::REG_MUX: mux_q <= s_wdata[MW-1:0];
					default: ; // read only or unmapped
				endcase
			end else if (s_bvalid && s_bready) begin
				s_bvalid <= 1'b0;
			end
			if (rd_fire) begin
				s_rvalid <= 1'b1;
			end else if (s_rvalid && s_rready) begin
				s_rvalid <= 1'b0;
			end
		end
	end

	// response payload, held while valid waits
	always_ff @(posedge clock_50) begin
		if (wr_fire) begin
			s_bresp <= wr_err ? us_regs_pkg::RESP_SLVERR : us_regs_pkg::RESP_OKAY;
		end
		if (rd_fire) begin
			s_rdata <= rd_word;
			s_rresp <= rd_err ? us_regs_pkg::RESP_SLVERR : us_regs_pkg::RESP_OKAY;
		end
	end

	// go levels become delayed start pulses
	delayed_pulser #(.DELAY(`US_START_DELAY)) u_spi_start (
		.clock_50 (clock_50),
		.rst_n (rst_n),
		.level (ctrl_q.f.spi_go),
		.pulse (spi.start)
	);

	delayed_pulser #(.DELAY(`US_START_DELAY)) u_acq_start (
		.clock_50 (clock_50),
		.rst_n (rst_n),
		.level (ctrl_q.f.acq_go),
		.pulse (acq.start)
	);

	assign spi.num_bits = nbits_q;
	assign spi.tx_data = tx_q;
	assign acq.init_delay = init_delay_q;
	assign acq.samples = samples_q;
	assign acq.tx_len = tx_len_q;

	assign pulser_en = ctrl_q.f.pulser_en;
	assign txrx_spi_en = ctrl_q.f.txrx_spi_en;
	assign txrx_sw_off = ctrl_q.f.txrx_sw_off;
	assign bf_reset = ctrl_q.f.bf_reset;
	assign mux_cnt = mux_q;

endmodule

//--- us_frontend_top.sv
`timescale 1ns/1ps
`include "us_settings.svh"

module us_frontend_top (
	input logic clock_50,
	input logic rst_n,
	// ==============================
	// axi4-lite slave
	// ==============================
	input logic [`US_AXI_ADDR_WIDTH-1:0] s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input logic [`US_AXI_DATA_WIDTH-1:0] s_wdata,
	input logic [`US_AXI_DATA_WIDTH/8-1:0] s_wstrb,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input logic [`US_AXI_ADDR_WIDTH-1:0] s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output logic [`US_AXI_DATA_WIDTH-1:0] s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,
	// ==============================
	// beamformer and board controls
	// ==============================
	output logic bf_spi_cs_n,
	output logic bf_spi_sck,
	output logic bf_spi_sdo,
	input logic bf_spi_sdi,
	output logic bf_tx_en,
	output logic bf_reset,
	output logic pulser_en,
	output logic txrx_spi_en, // lm96530 t/r switch
	output logic txrx_sw_off,
	output logic [`US_MUX_WIDTH-1:0] mux_cnt,
	output logic fifo_en // acquisition window
);

	spi_cmd_if u_spi_if ();
	acq_cfg_if u_acq_if ();

	us_axil_regs u_regs (
		.clock_50 (clock_50),
		.rst_n (rst_n),
		.s_awaddr (s_awaddr),
		.s_awvalid (s_awvalid),
		.s_awready (s_awready),
		.s_wdata (s_wdata),
		.s_wstrb (s_wstrb),
		.s_wvalid (s_wvalid),
		.s_wready (s_wready),
		.s_bresp (s_bresp),
		.s_bvalid (s_bvalid),
		.s_bready (s_bready),
		.s_araddr (s_araddr),
		.s_arvalid (s_arvalid),
		.s_arready (s_arready),
		.s_rdata (s_rdata),
		.s_rresp (s_rresp),
		.s_rvalid (s_rvalid),
		.s_rready (s_rready),
		.spi (u_spi_if.master),
		.acq (u_acq_if.master),
		.pulser_en (pulser_en),
		.txrx_spi_en (txrx_spi_en),
		.txrx_sw_off (txrx_sw_off),
		.bf_reset (bf_reset),
		.mux_cnt (mux_cnt)
	);

	lm96570_spi u_spi (
		.clock_50 (clock_50),
		.rst_n (rst_n),
		.cmd (u_spi_if.slave),
		.cs_n (bf_spi_cs_n),
		.sck (bf_spi_sck),
		.sdo (bf_spi_sdo),
		.sdi (bf_spi_sdi)
	);

	pulse_echo_fsm u_seq (
		.clock_50 (clock_50),
		.rst_n (rst_n),
		.cfg (u_acq_if.slave),
		.tx_en (bf_tx_en),
		.fifo_en (fifo_en)
	);

endmodule

//--- us_ifs.sv
`timescale 1ns/1ps
`include "us_settings.svh"

// ==============================
// register block to spi engine
// ==============================
interface spi_cmd_if;
	logic start; // single cycle launch
	logic [`US_BIT_COUNT_WIDTH-1:0] num_bits; // bits to shift
	logic [`US_SPI_DATA_WIDTH-1:0] tx_data; // msb at num_bits-1
	logic [`US_SPI_DATA_WIDTH-1:0] rx_data; // captured word
	logic done; // high until next start

	modport master (
		output start, num_bits, tx_data,
		input rx_data, done
	);
	modport slave (
		input start, num_bits, tx_data,
		output rx_data, done
	);
endinterface

// ==============================
// register block to sequencer
// ==============================
interface acq_cfg_if;
	logic start;
	logic [`US_TIMER_WIDTH-1:0] init_delay; // gap before window
	logic [`US_TIMER_WIDTH-1:0] samples; // window length
	logic [`US_TIMER_WIDTH-1:0] tx_len; // tx_en length
	logic done;

	modport master (
		output start, init_delay, samples, tx_len,
		input done
	);
	modport slave (
		input start, init_delay, samples, tx_len,
		output done
	);
endinterface

//--- us_regs_pkg.sv
`include "us_settings.svh"

package us_regs_pkg;

	// ==============================
	// byte offsets
	// ==============================
	localparam logic [`US_AXI_ADDR_WIDTH-1:0] REG_CTRL = 'h00; // control levels
	localparam logic [`US_AXI_ADDR_WIDTH-1:0] REG_STATUS = 'h04; // read only
	localparam logic [`US_AXI_ADDR_WIDTH-1:0] REG_SPI_NBITS = 'h08;
	localparam logic [`US_AXI_ADDR_WIDTH-1:0] REG_SPI_TX0 = 'h0C; // tx bits 31..0
	localparam logic [`US_AXI_ADDR_WIDTH-1:0] REG_SPI_TX1 = 'h10; // tx bits 63..32
	localparam logic [`US_AXI_ADDR_WIDTH-1:0] REG_SPI_TX2 = 'h14; // tx bits 69..64
	localparam logic [`US_AXI_ADDR_WIDTH-1:0] REG_SPI_RX0 = 'h18; // read only
	localparam logic [`US_AXI_ADDR_WIDTH-1:0] REG_SPI_RX1 = 'h1C;
	localparam logic [`US_AXI_ADDR_WIDTH-1:0] REG_SPI_RX2 = 'h20;
	localparam logic [`US_AXI_ADDR_WIDTH-1:0] REG_INIT_DELAY = 'h24;
	localparam logic [`US_AXI_ADDR_WIDTH-1:0] REG_SAMPLES = 'h28;
	localparam logic [`US_AXI_ADDR_WIDTH-1:0] REG_TX_LEN = 'h2C;
	localparam logic [`US_AXI_ADDR_WIDTH-1:0] REG_MUX = 'h30;

	// control word, bit 0 at the bottom
	typedef struct packed {
		logic [25:0] reserved;
		logic bf_reset; // bit 5
		logic txrx_sw_off; // bit 4
		logic txrx_spi_en; // bit 3
		logic pulser_en; // bit 2
		logic acq_go; // bit 1, level into start pulser
		logic spi_go; // bit 0
	} ctrl_fields_t;

	typedef union packed {
		logic [`US_AXI_DATA_WIDTH-1:0] raw; // bus view
		ctrl_fields_t f; // decoded view
	} ctrl_reg_u;

	localparam int STAT_SPI_DONE = 0;
	localparam int STAT_ACQ_DONE = 1;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- us_seq_pkg.sv
package us_seq_pkg;

	// beamformer serial engine
	typedef enum logic [1:0] {
		SPI_IDLE, // after reset, done low
		SPI_SHIFT, // cs_n low, bits moving
		SPI_DONE // transfer finished, done held
	} spi_state_e;

	// pulse-echo sequencer
	typedef enum logic [2:0] {
		ACQ_IDLE,
		ACQ_TX, // tx_en high
		ACQ_DELAY, // wait before window
		ACQ_WINDOW, // fifo_en high
		ACQ_DONE
	} acq_state_e;

endpackage

//--- us_settings.svh
`ifndef US_SETTINGS_SVH
`define US_SETTINGS_SVH

// ==============================
// beamformer serial link
// ==============================
`define US_SPI_DATA_WIDTH 70 // lm96570 shift word
`define US_BIT_COUNT_WIDTH 8 // holds 0..255 bit count
`define US_SCK_HALF_DIV 12 // clock_50 cycles per sck half period

// ==============================
// sequencer and control
// ==============================
`define US_TIMER_WIDTH 32 // tx_len, init_delay, samples
`define US_MUX_WIDTH 11 // mux board select lines
`define US_START_DELAY 10 // start pulser latency in cycles

// ==============================
// register bus
// ==============================
`define US_AXI_ADDR_WIDTH 6 // byte address, 16 word slots
`define US_AXI_DATA_WIDTH 32

`endif
